/* logic/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	typedef logic [31:0] word_t; // registers, alu, memory data, pc
	typedef logic [4:0] regAddr_t;

	typedef enum logic [5:0] {
		opRtype = 6'h03,
		opJ     = 6'h02,
		opJal   = 6'h07,
		opAddi  = 6'h09,
		opAndi  = 6'h0c,
		opOri   = 6'h0e,
		opBeq   = 6'h05,
		opBne   = 6'h04,
		opLbu   = 6'h22,
		opLui   = 6'h0f,
		opLw    = 6'h12,
		opSb    = 6'h28,
		opSw    = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		fnJr   = 6'h08,
		fnLwn  = 6'h21, // custom, rt <= mem[rs + rd]
		fnSwn  = 6'h13, // custom, mem[rs + rd] <= rt
		fnAdd  = 6'h20,
		fnSub  = 6'h22,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnNor  = 6'h27,
		fnSlt  = 6'h2a,
		fnSltu = 6'h2b,
		fnSll  = 6'h00,
		fnSrl  = 6'h02
	} func_t;

	typedef enum logic [2:0] {
		aluByFunc = 3'd0,
		aluAdd    = 3'd1,
		aluSub    = 3'd2,
		aluAnd    = 3'd3,
		aluOr     = 3'd4
	} aluOp_t;

	typedef enum logic [1:0] {destRt = 2'd0, destRd = 2'd1, destRa = 2'd2} regDest_t;
	typedef enum logic [1:0] {src2Reg = 2'd0, src2Imm = 2'd1, src2Pc8 = 2'd2} aluSrc2_t;
	typedef enum logic [1:0] {jumpNone = 2'd0, jumpTarget = 2'd1, jumpReg = 2'd2} jump_t;
	typedef enum logic [1:0] {branchNone = 2'd0, branchEq = 2'd1, branchNe = 2'd2} branch_t;
	typedef enum logic [1:0] {wbAlu = 2'd0, wbMem = 2'd1, wbUpper = 2'd2} regSrc_t;
	typedef enum logic [1:0] {memNone = 2'd0, memWrite = 2'd1, memRead = 2'd2} memOp_t;

	// decoder output bundle
	typedef struct packed {
		aluOp_t   aluOp;
		logic     regWrite;
		regDest_t regDest;
		logic     aluSrc1Rs; // 0 selects constant zero
		aluSrc2_t aluSrc2;
		jump_t    jump;
		branch_t  branch;
		regSrc_t  regSrc;
		logic     zeroExtImm;
		logic     byteAccess;
		logic     readRegRd; // second read port takes rd instead of rt
		logic     memDataRt; // store data is rt while rd feeds the address
		memOp_t   memOp;
	} ctrl_t;

endpackage

`default_nettype wire

/* logic/coreCtrlIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface coreCtrlIf #(
	parameter int ImemWords = 256
) ();

	logic run;
	logic start; // one cycle, restarts pc
	logic imemWe;
	logic [$clog2(ImemWords)-1:0] imemAddr; // word index
	cpuPkg::word_t imemData;
	logic halted;
	cpuPkg::word_t pc;
	cpuPkg::regAddr_t dbgRegAddr;
	cpuPkg::word_t dbgRegData;

	modport host (
		output run, start, imemWe, imemAddr, imemData, dbgRegAddr,
		input halted, pc, dbgRegData
	);

	modport core (
		input run, start, imemWe, imemAddr, imemData, dbgRegAddr,
		output halted, pc, dbgRegData
	);

endinterface

`default_nettype wire

/* logic/controlUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
	input  cpuPkg::opcode_t opcode,
	input  cpuPkg::func_t   func,
	output cpuPkg::ctrl_t   ctrl
);

	always_comb begin
		// defaults: nothing written, no flow change, rs on the first operand
		ctrl.aluOp      = cpuPkg::aluAdd;
		ctrl.regWrite   = 1'b0;
		ctrl.regDest    = cpuPkg::destRt;
		ctrl.aluSrc1Rs  = 1'b1;
		ctrl.aluSrc2    = cpuPkg::src2Reg;
		ctrl.jump       = cpuPkg::jumpNone;
		ctrl.branch     = cpuPkg::branchNone;
		ctrl.regSrc     = cpuPkg::wbAlu;
		ctrl.zeroExtImm = 1'b0;
		ctrl.byteAccess = 1'b0;
		ctrl.readRegRd  = 1'b0;
		ctrl.memDataRt  = 1'b0;
		ctrl.memOp      = cpuPkg::memNone;

		case (opcode)
			cpuPkg::opRtype: begin
				ctrl.aluOp = cpuPkg::aluByFunc;
				case (func)
					cpuPkg::fnJr: ctrl.jump = cpuPkg::jumpReg;
					cpuPkg::fnLwn: begin
						ctrl.aluOp     = cpuPkg::aluAdd; // rs + rd
						ctrl.regWrite  = 1'b1;
						ctrl.readRegRd = 1'b1;
						ctrl.memOp     = cpuPkg::memRead;
						ctrl.regSrc    = cpuPkg::wbMem;
					end
					cpuPkg::fnSwn: begin
						ctrl.aluOp     = cpuPkg::aluAdd;
						ctrl.readRegRd = 1'b1;
						ctrl.memDataRt = 1'b1;
						ctrl.memOp     = cpuPkg::memWrite;
					end
					cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd, cpuPkg::fnOr, cpuPkg::fnNor,
					cpuPkg::fnSlt, cpuPkg::fnSltu, cpuPkg::fnSll, cpuPkg::fnSrl: begin
						ctrl.regWrite = 1'b1;
						ctrl.regDest  = cpuPkg::destRd;
					end
					default: ctrl.aluOp = cpuPkg::aluByFunc; // unknown func is a no-op
				endcase
			end
			cpuPkg::opJ: ctrl.jump = cpuPkg::jumpTarget;
			cpuPkg::opJal: begin
				ctrl.jump      = cpuPkg::jumpTarget;
				ctrl.regWrite  = 1'b1;
				ctrl.regDest   = cpuPkg::destRa;
				ctrl.aluSrc1Rs = 1'b0; // 0 + (pc+8)
				ctrl.aluSrc2   = cpuPkg::src2Pc8;
			end
			cpuPkg::opAddi, cpuPkg::opAndi, cpuPkg::opOri: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc2  = cpuPkg::src2Imm;
				if (opcode == cpuPkg::opAndi) begin
					ctrl.aluOp      = cpuPkg::aluAnd;
					ctrl.zeroExtImm = 1'b1;
				end else if (opcode == cpuPkg::opOri) begin
					ctrl.aluOp      = cpuPkg::aluOr;
					ctrl.zeroExtImm = 1'b1;
				end
			end
			cpuPkg::opBeq, cpuPkg::opBne: begin
				ctrl.aluOp  = cpuPkg::aluSub; // compare through zero flag
				ctrl.branch = (opcode == cpuPkg::opBeq) ? cpuPkg::branchEq : cpuPkg::branchNe;
			end
			cpuPkg::opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.regSrc   = cpuPkg::wbUpper;
			end
			cpuPkg::opLw, cpuPkg::opLbu: begin
				ctrl.regWrite   = 1'b1;
				ctrl.aluSrc2    = cpuPkg::src2Imm;
				ctrl.memOp      = cpuPkg::memRead;
				ctrl.regSrc     = cpuPkg::wbMem;
				ctrl.byteAccess = (opcode == cpuPkg::opLbu);
			end
			cpuPkg::opSw, cpuPkg::opSb: begin
				ctrl.aluSrc2    = cpuPkg::src2Imm;
				ctrl.memOp      = cpuPkg::memWrite;
				ctrl.byteAccess = (opcode == cpuPkg::opSb);
			end
			default: ctrl.regWrite = 1'b0;
		endcase
	end

	always_comb begin
		assert (ctrl.memOp != 2'b11 && !(ctrl.memOp == cpuPkg::memWrite && ctrl.regWrite))
			else $error("controlUnit: store with register write or bad memOp");
	end

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
	input  cpuPkg::aluOp_t aluOp,
	input  cpuPkg::func_t  func,
	input  logic [4:0]     shamt,
	input  cpuPkg::word_t  a,
	input  cpuPkg::word_t  b,
	output cpuPkg::word_t  result,
	output logic           zero
);

	always_comb begin
		case (aluOp)
			cpuPkg::aluSub: result = a - b;
			cpuPkg::aluAnd: result = a & b;
			cpuPkg::aluOr:  result = a | b;
			cpuPkg::aluByFunc: begin
				case (func)
					cpuPkg::fnSub:  result = a - b;
					cpuPkg::fnAnd:  result = a & b;
					cpuPkg::fnOr:   result = a | b;
					cpuPkg::fnNor:  result = ~(a | b);
					cpuPkg::fnSlt:  result = {31'b0, $signed(a) < $signed(b)};
					cpuPkg::fnSltu: result = {31'b0, a < b};
					cpuPkg::fnSll:  result = b << shamt; // shifts act on rt
					cpuPkg::fnSrl:  result = b >> shamt;
					default:        result = a + b;
				endcase
			end
			default: result = a + b;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* logic/registerFile.sv */
`timescale 1ns/100ps
`default_nettype none

module registerFile (
	input  logic             clk,
	input  cpuPkg::regAddr_t readAddrA,
	input  cpuPkg::regAddr_t readAddrB,
	input  cpuPkg::regAddr_t dbgAddr,
	input  logic             writeEnable,
	input  cpuPkg::regAddr_t writeAddr,
	input  cpuPkg::word_t    writeData,
	output cpuPkg::word_t    readDataA,
	output cpuPkg::word_t    readDataB,
	output cpuPkg::word_t    dbgData
);

	cpuPkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (writeEnable && writeAddr != '0)
			regs[writeAddr] <= writeData; // $0 stays zero
	end

	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];
	assign dbgData   = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

`default_nettype wire

/* logic/dataMemory.sv */
`timescale 1ns/100ps
`default_nettype none

module dataMemory #(
	parameter int DmemBytes = 1024
) (
	input  logic           clk,
	input  cpuPkg::memOp_t memOp,
	input  logic           byteAccess,
	input  cpuPkg::word_t  address,
	input  cpuPkg::word_t  writeData,
	output cpuPkg::word_t  readData
);

	localparam int AddrW = $clog2(DmemBytes);

	logic [7:0] mem [DmemBytes];
	logic [AddrW-1:0] byteIdx;
	logic [AddrW-1:0] wordIdx;
	cpuPkg::word_t wordData;

	assign byteIdx = address[AddrW-1:0];
	assign wordIdx = {address[AddrW-1:2], 2'b00}; // word accesses ignore low bits

	// little endian
	assign wordData = {mem[wordIdx + 3], mem[wordIdx + 2], mem[wordIdx + 1], mem[wordIdx]};

	always_comb begin
		if (memOp != cpuPkg::memRead)
			readData = '0;
		else if (byteAccess)
			readData = {24'b0, mem[byteIdx]}; // lbu
		else
			readData = wordData;
	end

	always_ff @(posedge clk) begin
		if (memOp == cpuPkg::memWrite) begin
			if (byteAccess) begin
				mem[byteIdx] <= writeData[7:0];
			end else begin
				mem[wordIdx]     <= writeData[7:0];
				mem[wordIdx + 1] <= writeData[15:8];
				mem[wordIdx + 2] <= writeData[23:16];
				mem[wordIdx + 3] <= writeData[31:24];
			end
		end
	end

endmodule

`default_nettype wire

/* logic/cpuCore.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuCore #(
	parameter int ImemWords = 256,
	parameter int DmemBytes = 1024
) (
	input logic      clk,
	input logic      reset,
	coreCtrlIf.core  ctrlBus
);

	localparam int ImemAddrW = $clog2(ImemWords);

	cpuPkg::word_t imem [ImemWords];
	cpuPkg::word_t pc, instr, nextPc, pcPlus4, branchTarget, jumpTarget;
	cpuPkg::word_t immExt, aluA, aluB, aluResult, memReadData, writeBack;
	cpuPkg::word_t readDataA, readDataB, dbgData;
	cpuPkg::ctrl_t ctrl;
	cpuPkg::opcode_t opcode;
	cpuPkg::regAddr_t rs, rt, rd, regBAddr, destAddr, dbgAddr;
	cpuPkg::memOp_t memOp;
	logic halted, aluZero, branchTaken, selfJump, advance;

	assign instr  = imem[pc[ImemAddrW+1:2]];
	assign opcode = cpuPkg::opcode_t'(instr[31:26]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	// one instruction per clock while running, none in the start cycle
	assign advance = ctrlBus.run && !halted && !ctrlBus.start;

	controlUnit decoder (.opcode(opcode), .func(cpuPkg::func_t'(instr[5:0])), .ctrl(ctrl));

	assign regBAddr = ctrl.readRegRd ? rd : rt;
	// swn borrows the debug port for rt; host register reads mean nothing mid-run
	assign dbgAddr = (ctrlBus.run && ctrl.memDataRt) ? rt : ctrlBus.dbgRegAddr;

	always_comb begin
		case (ctrl.regDest)
			cpuPkg::destRd: destAddr = rd;
			cpuPkg::destRa: destAddr = 5'd31;
			default:        destAddr = rt;
		endcase
	end

	registerFile regs (
		.clk(clk), .readAddrA(rs), .readAddrB(regBAddr), .dbgAddr(dbgAddr),
		.writeEnable(advance && ctrl.regWrite), .writeAddr(destAddr), .writeData(writeBack),
		.readDataA(readDataA), .readDataB(readDataB), .dbgData(dbgData)
	);

	assign immExt = ctrl.zeroExtImm ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
	assign aluA = ctrl.aluSrc1Rs ? readDataA : '0;

	always_comb begin
		case (ctrl.aluSrc2)
			cpuPkg::src2Imm: aluB = immExt;
			cpuPkg::src2Pc8: aluB = pc + 32'd8; // jal link
			default:         aluB = readDataB;
		endcase
	end

	alu alu0 (
		.aluOp(ctrl.aluOp), .func(cpuPkg::func_t'(instr[5:0])), .shamt(instr[10:6]),
		.a(aluA), .b(aluB), .result(aluResult), .zero(aluZero)
	);

	assign memOp = advance ? ctrl.memOp : cpuPkg::memNone;

	dataMemory #(.DmemBytes(DmemBytes)) dmem (
		.clk(clk), .memOp(memOp), .byteAccess(ctrl.byteAccess), .address(aluResult),
		.writeData(ctrl.memDataRt ? dbgData : readDataB), .readData(memReadData)
	);

	always_comb begin
		case (ctrl.regSrc)
			cpuPkg::wbMem:   writeBack = memReadData;
			cpuPkg::wbUpper: writeBack = {instr[15:0], 16'b0}; // lui
			default:         writeBack = aluResult;
		endcase
	end

	// next pc
	assign pcPlus4 = pc + 32'd4;
	assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
	assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};
	assign branchTaken = (ctrl.branch == cpuPkg::branchEq && aluZero) ||
		(ctrl.branch == cpuPkg::branchNe && !aluZero);

	always_comb begin
		case (ctrl.jump)
			cpuPkg::jumpTarget: nextPc = jumpTarget;
			cpuPkg::jumpReg:    nextPc = readDataA; // jr
			default:            nextPc = branchTaken ? branchTarget : pcPlus4;
		endcase
	end

	assign selfJump = (opcode == cpuPkg::opJ) && (jumpTarget == pc);

	always_ff @(posedge clk) begin
		if (reset || ctrlBus.start) begin
			pc     <= '0;
			halted <= 1'b0;
		end else if (advance) begin
			pc <= nextPc;
			if (selfJump)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrlBus.imemWe)
			imem[ctrlBus.imemAddr] <= ctrlBus.imemData;
	end

	assign ctrlBus.pc = pc;
	assign ctrlBus.halted = halted;
	assign ctrlBus.dbgRegData = dbgData;

	imemStable: assert property (@(posedge clk) disable iff (reset)
		ctrlBus.imemWe |-> !ctrlBus.run)
		else $error("cpuCore: instruction memory written while running");

endmodule

`default_nettype wire

/* logic/hostRegs.sv */
`timescale 1ns/100ps
`default_nettype none

module hostRegs #(
	parameter int ImemWords = 256
) (
	input  logic          clk,
	input  logic          reset,
	input  logic          awvalid,
	output logic          awready,
	input  logic [15:0]   awaddr,
	input  logic          wvalid,
	output logic          wready,
	input  cpuPkg::word_t wdata,
	output logic          bvalid,
	input  logic          bready,
	output logic [1:0]    bresp,
	input  logic          arvalid,
	output logic          arready,
	input  logic [15:0]   araddr,
	output logic          rvalid,
	input  logic          rready,
	output cpuPkg::word_t rdata,
	output logic [1:0]    rresp,
	coreCtrlIf.host       ctrlBus
);

	localparam int ImemAddrW = $clog2(ImemWords);
	localparam logic [1:0] RespOkay = 2'b00;
	localparam logic [1:0] RespSlvErr = 2'b10;

	logic writeIdle, writeAccept, readAccept, isCtrl, isImem, run;
	cpuPkg::word_t readValue;

	assign writeAccept = writeIdle && awvalid && wvalid;
	assign awready = writeAccept; // address and data taken together
	assign wready = writeAccept;
	assign readAccept = arvalid && arready;

	assign isCtrl = (awaddr == 16'h0000);
	assign isImem = (awaddr[15:12] == 4'h1) && (int'(awaddr[11:2]) < ImemWords);

	always_ff @(posedge clk) begin
		if (reset) begin
			writeIdle      <= 1'b0;
			bvalid         <= 1'b0;
			arready        <= 1'b0;
			rvalid         <= 1'b0;
			run            <= 1'b0;
			ctrlBus.start  <= 1'b0;
			ctrlBus.imemWe <= 1'b0;
		end else begin
			ctrlBus.start  <= 1'b0;
			ctrlBus.imemWe <= 1'b0;
			if (writeAccept) begin
				writeIdle <= 1'b0;
				bvalid    <= 1'b1;
				if (isCtrl) begin
					run           <= wdata[0];
					ctrlBus.start <= wdata[0];
				end
				if (isImem && !run)
					ctrlBus.imemWe <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid    <= 1'b0;
				writeIdle <= 1'b1;
			end else if (!bvalid) begin
				writeIdle <= 1'b1;
			end
			// reads
			if (readAccept) begin
				arready <= 1'b0;
				rvalid  <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid  <= 1'b0;
				arready <= 1'b1;
			end else if (!rvalid) begin
				arready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (writeAccept) begin
			bresp <= (isCtrl || (isImem && !run)) ? RespOkay : RespSlvErr;
			ctrlBus.imemAddr <= awaddr[ImemAddrW+1:2];
			ctrlBus.imemData <= wdata;
		end
		if (readAccept)
			rdata <= readValue;
	end

	assign ctrlBus.dbgRegAddr = araddr[6:2];

	always_comb begin
		if (araddr == 16'h0000)
			readValue = {31'b0, run};
		else if (araddr == 16'h0004)
			readValue = {31'b0, ctrlBus.halted};
		else if (araddr == 16'h0008)
			readValue = ctrlBus.pc;
		else if (araddr[15:7] == 9'h002) // 0x100 to 0x17c
			readValue = ctrlBus.dbgRegData;
		else
			readValue = '0; // unmapped reads give zero
	end

	assign rresp = RespOkay;
	assign ctrlBus.run = run;

	bvalidHeld: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else $error("hostRegs: write response dropped before bready");

endmodule

`default_nettype wire

/* logic/cpuTop.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTop #(
	parameter int ImemWords = 256,
	parameter int DmemBytes = 1024
) (
	input  logic          clk,
	input  logic          reset,
	input  logic          awvalid,
	output logic          awready,
	input  logic [15:0]   awaddr,
	input  logic          wvalid,
	output logic          wready,
	input  cpuPkg::word_t wdata,
	output logic          bvalid,
	input  logic          bready,
	output logic [1:0]    bresp,
	input  logic          arvalid,
	output logic          arready,
	input  logic [15:0]   araddr,
	output logic          rvalid,
	input  logic          rready,
	output cpuPkg::word_t rdata,
	output logic [1:0]    rresp
);

	coreCtrlIf #(.ImemWords(ImemWords)) ctrlBus ();

	hostRegs #(.ImemWords(ImemWords)) host (
		.clk(clk), .reset(reset),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.ctrlBus(ctrlBus.host)
	);

	cpuCore #(.ImemWords(ImemWords), .DmemBytes(DmemBytes)) core (
		.clk(clk), .reset(reset), .ctrlBus(ctrlBus.core)
	);

endmodule

`default_nettype wire

/* test/cpuRefModel.svh */
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

localparam logic [5:0] opRtype = 6'h03, opJ = 6'h02, opJal = 6'h07;
localparam logic [5:0] opAddi = 6'h09, opAndi = 6'h0c, opOri = 6'h0e, opLui = 6'h0f;
localparam logic [5:0] opBeq = 6'h05, opBne = 6'h04;
localparam logic [5:0] opLw = 6'h12, opLbu = 6'h22, opSw = 6'h2b, opSb = 6'h28;
localparam logic [5:0] fnJr = 6'h08, fnLwn = 6'h21, fnSwn = 6'h13;
localparam logic [5:0] fnAdd = 6'h20, fnSub = 6'h22, fnAnd = 6'h24, fnOr = 6'h25;
localparam logic [5:0] fnNor = 6'h27, fnSlt = 6'h2a, fnSltu = 6'h2b, fnSll = 6'h00, fnSrl = 6'h02;
localparam int modelMemBytes = 1024;

logic [31:0] progMem [256];
int progLen;
logic [31:0] modelRegs [32]; // persists from one program to the next, like the core
logic [7:0] modelMem [modelMemBytes];
logic [31:0] modelPc;

// add rd, rs, rt
function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
	return {opRtype, rs, rt, rd, sh, fn};
endfunction

// addi rt, rs, imm and lw rt, imm(rs)
function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] encJ(input logic [5:0] op, input int wordIdx);
	logic [25:0] field;
	field = 26'(wordIdx);
	return {op, field};
endfunction

function automatic void emit(input logic [31:0] ins);
	progMem[progLen] = ins;
	progLen++;
endfunction

function automatic void clearModel();
	foreach (modelRegs[i])
		modelRegs[i] = 'x;
	modelRegs[0] = '0;
	foreach (modelMem[i])
		modelMem[i] = 'x;
endfunction

function automatic void setReg(input logic [4:0] r, input logic [31:0] v);
	if (r != 5'd0)
		modelRegs[r] = v;
endfunction

function automatic int memIndex(input logic [31:0] addr);
	return int'(addr % modelMemBytes);
endfunction

function automatic logic [31:0] loadWord(input logic [31:0] addr);
	int base;
	base = memIndex({addr[31:2], 2'b00});
	return {modelMem[base + 3], modelMem[base + 2], modelMem[base + 1], modelMem[base]};
endfunction

function automatic void storeWord(input logic [31:0] addr, input logic [31:0] v);
	int base;
	base = memIndex({addr[31:2], 2'b00});
	modelMem[base] = v[7:0]; // little endian
	modelMem[base + 1] = v[15:8];
	modelMem[base + 2] = v[23:16];
	modelMem[base + 3] = v[31:24];
endfunction

// runs progMem from pc 0 until the self jump; returns the step count, 0 if never halted
function automatic int runModel(input int stepLimit);
	logic [31:0] ins, a, b, se, ze, pc4, target;
	logic [5:0] op, fn;
	logic [4:0] rs, rt, rd;
	int steps;
	modelPc = 32'd0;
	for (steps = 1; steps <= stepLimit; steps++) begin
		ins = progMem[modelPc[9:2]];
		op = ins[31:26];
		fn = ins[5:0];
		rs = ins[25:21];
		rt = ins[20:16];
		rd = ins[15:11];
		a = modelRegs[rs];
		b = modelRegs[rt];
		se = {{16{ins[15]}}, ins[15:0]};
		ze = {16'h0, ins[15:0]};
		pc4 = modelPc + 32'd4;
		target = {pc4[31:28], ins[25:0], 2'b00};
		if (op == opJ && target == modelPc)
			return steps; // halt loop, pc stays put
		modelPc = pc4;
		case (op)
			opRtype: begin
				case (fn)
					fnAdd: setReg(rd, a + b);
					fnSub: setReg(rd, a - b);
					fnAnd: setReg(rd, a & b);
					fnOr: setReg(rd, a | b);
					fnNor: setReg(rd, ~(a | b));
					fnSlt: setReg(rd, {31'h0, $signed(a) < $signed(b)});
					fnSltu: setReg(rd, {31'h0, a < b});
					fnSll: setReg(rd, b << ins[10:6]);
					fnSrl: setReg(rd, b >> ins[10:6]);
					fnJr: modelPc = a;
					fnLwn: setReg(rt, loadWord(a + modelRegs[rd]));
					fnSwn: storeWord(a + modelRegs[rd], b);
					default: ;
				endcase
			end
			opJ: modelPc = target;
			opJal: begin
				setReg(5'd31, pc4 + 32'd4); // link is pc+8, no delay slot
				modelPc = target;
			end
			opAddi: setReg(rt, a + se);
			opAndi: setReg(rt, a & ze);
			opOri: setReg(rt, a | ze);
			opLui: setReg(rt, {ins[15:0], 16'h0});
			opBeq: if (a == b) modelPc = pc4 + (se << 2);
			opBne: if (a != b) modelPc = pc4 + (se << 2);
			opLw: setReg(rt, loadWord(a + se));
			opLbu: setReg(rt, {24'h0, modelMem[memIndex(a + se)]});
			opSw: storeWord(a + se, b);
			opSb: modelMem[memIndex(a + se)] = b[7:0];
			default: ;
		endcase
	end
	return 0;
endfunction

`endif

/* test/cpuTb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuTb;

	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;
	localparam int stepLimit = 1000;
	localparam int pollLimit = 200;
	// about 100 program words, up to 10 steps each, plus about 500 bus accesses
	localparam int watchdogNs = (100 * 10 + 500 * 16) * 20;

	logic clk, reset;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic [15:0] awaddr, araddr;
	logic [31:0] wdata;
	logic awready, wready, bvalid, arready, rvalid;
	logic [1:0] bresp, rresp;
	logic [31:0] rdata;
	int seed;
	int readyDelay; // cycles before bready or rready rises
	event checkRequest, checkDone;

	`include "cpuRefModel.svh"

	cpuTop DUT (
		.clk(clk), .reset(reset),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
	);

	always #10 clk = ~clk;

	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic axiWrite(input logic [15:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		awvalid <= 1'b1;
		awaddr <= addr;
		wvalid <= 1'b1;
		wdata <= data;
		do @(posedge clk); while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		repeat (readyDelay) @(posedge clk);
		bready <= 1'b1;
		do @(posedge clk); while (!bvalid);
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [15:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		arvalid <= 1'b1;
		araddr <= addr;
		do @(posedge clk); while (!arready);
		arvalid <= 1'b0;
		repeat (readyDelay) @(posedge clk);
		rready <= 1'b1;
		do @(posedge clk); while (!rvalid);
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	task automatic writeExpect(input logic [15:0] addr, input logic [31:0] data,
			input logic [1:0] exp, input string what);
		logic [1:0] resp;
		axiWrite(addr, data, resp);
		checkValue(what, {30'h0, resp}, {30'h0, exp});
	endtask

	task automatic loadProgram();
		for (int i = 0; i < progLen; i++)
			writeExpect(16'h1000 + 16'(4 * i), progMem[i], respOkay, "imem write response");
	endtask

	// start, then poll status until halted
	task automatic startAndWait();
		logic [31:0] data;
		logic [1:0] resp;
		int polls;
		writeExpect(16'h0000, 32'h1, respOkay, "start response");
		// every program runs longer than the first poll takes
		axiRead(16'h0004, data, resp);
		checkValue("status right after start", data, 32'h0);
		polls = 1;
		while (data[0] !== 1'b1 && polls < pollLimit) begin
			axiRead(16'h0004, data, resp);
			polls++;
		end
		assert (data[0] === 1'b1) else begin
			$display("core never reached its halt loop after %0d status polls", polls);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic buildAluProgram();
		logic [31:0] v;
		int s1, s2;
		progLen = 0;
		for (int r = 1; r <= 6; r++) begin
			v = $random(seed);
			emit(encI(opLui, 5'(r), 5'd0, v[31:16]));
			emit(encI(opOri, 5'(r), 5'(r), v[15:0]));
		end
		for (int r = 7; r < 32; r++) begin
			s1 = 1 + int'($unsigned($random(seed)) % (r - 1)); // only registers set above
			s2 = 1 + int'($unsigned($random(seed)) % (r - 1));
			v = $random(seed);
			case ((r - 7) % 13)
				0: emit(encR(fnAdd, 5'(r), 5'(s1), 5'(s2), 5'd0));
				1: emit(encR(fnSub, 5'(r), 5'(s1), 5'(s2), 5'd0));
				2: emit(encR(fnAnd, 5'(r), 5'(s1), 5'(s2), 5'd0));
				3: emit(encR(fnOr, 5'(r), 5'(s1), 5'(s2), 5'd0));
				4: emit(encR(fnNor, 5'(r), 5'(s1), 5'(s2), 5'd0));
				5: emit(encR(fnSlt, 5'(r), 5'(s1), 5'(s2), 5'd0));
				6: emit(encR(fnSltu, 5'(r), 5'(s1), 5'(s2), 5'd0));
				7: emit(encR(fnSll, 5'(r), 5'd0, 5'(s2), v[4:0]));
				8: emit(encR(fnSrl, 5'(r), 5'd0, 5'(s2), v[4:0]));
				9: emit(encI(opAddi, 5'(r), 5'(s1), v[15:0]));
				10: emit(encI(opAndi, 5'(r), 5'(s1), v[15:0]));
				11: emit(encI(opOri, 5'(r), 5'(s1), v[15:0]));
				default: emit(encI(opLui, 5'(r), 5'd0, v[15:0]));
			endcase
		end
		emit(encJ(opJ, progLen));
	endtask

	task automatic buildMemProgram();
		logic [31:0] va, vb;
		progLen = 0;
		va = $random(seed);
		vb = $random(seed);
		emit(encI(opAddi, 5'd1, 5'd0, 16'h0100)); // base address
		emit(encI(opLui, 5'd2, 5'd0, va[31:16]));
		emit(encI(opOri, 5'd2, 5'd2, va[15:0]));
		emit(encI(opLui, 5'd3, 5'd0, vb[31:16]));
		emit(encI(opOri, 5'd3, 5'd3, vb[15:0]));
		emit(encI(opSw, 5'd2, 5'd1, 16'd0));
		emit(encI(opSw, 5'd3, 5'd1, 16'd4));
		emit(encI(opSw, 5'd2, 5'd1, 16'd8));
		emit(encI(opSb, 5'd3, 5'd1, 16'd5));
		emit(encI(opSb, 5'd2, 5'd1, 16'd10));
		emit(encI(opAddi, 5'd4, 5'd0, 16'd12));
		emit(encR(fnSwn, 5'd4, 5'd1, 5'd3, 5'd0)); // mem[r1 + r4] = r3
		emit(encI(opAddi, 5'd15, 5'd1, 16'd16));
		emit(encI(opSb, 5'd2, 5'd15, 16'hfffe)); // negative offset
		emit(encI(opLw, 5'd5, 5'd1, 16'd0));
		emit(encI(opLw, 5'd6, 5'd1, 16'd4));
		emit(encI(opLw, 5'd7, 5'd1, 16'd8));
		emit(encI(opLw, 5'd8, 5'd1, 16'd12));
		emit(encI(opLbu, 5'd9, 5'd1, 16'd5));
		emit(encI(opLbu, 5'd10, 5'd1, 16'd10));
		emit(encI(opLbu, 5'd11, 5'd1, 16'd3));
		emit(encI(opAddi, 5'd13, 5'd0, 16'd4));
		emit(encR(fnLwn, 5'd4, 5'd1, 5'd12, 5'd0)); // r12 = mem[r1 + r4]
		emit(encR(fnLwn, 5'd13, 5'd1, 5'd14, 5'd0));
		emit(encI(opLw, 5'd16, 5'd15, 16'hfff4));
		emit(encI(opLw, 5'd17, 5'd1, 16'd2)); // low address bits dropped
		emit(encJ(opJ, progLen));
	endtask

	// word index in the comments, branch offsets count from the next word
	task automatic buildBranchProgram();
		progLen = 0;
		emit(encI(opAddi, 5'd1, 5'd0, 16'd0)); // 0 counter
		emit(encI(opAddi, 5'd2, 5'd0, 16'd5)); // 1 limit
		emit(encI(opAddi, 5'd3, 5'd0, 16'd0)); // 2 sum
		emit(encI(opAddi, 5'd1, 5'd1, 16'd1)); // 3 loop
		emit(encR(fnAdd, 5'd3, 5'd3, 5'd1, 5'd0)); // 4
		emit(encI(opBne, 5'd2, 5'd1, 16'hfffd)); // 5 back to 3
		emit(encI(opBeq, 5'd2, 5'd1, 16'd1)); // 6 taken to 8
		emit(encI(opAddi, 5'd4, 5'd0, 16'd99)); // 7 skipped
		emit(encI(opBeq, 5'd1, 5'd0, 16'd1)); // 8 not taken
		emit(encI(opAddi, 5'd5, 5'd0, 16'd7)); // 9
		emit(encJ(opJal, 14)); // 10, ra = 48
		emit(encI(opAddi, 5'd6, 5'd0, 16'd11)); // 11 passed over by the pc+8 link
		emit(encJ(opJ, 16)); // 12
		emit(encI(opAddi, 5'd8, 5'd0, 16'd1)); // 13 dead
		emit(encI(opAddi, 5'd7, 5'd31, 16'd0)); // 14 copy ra
		emit(encR(fnJr, 5'd0, 5'd31, 5'd0, 5'd0)); // 15
		emit(encJ(opJ, 16)); // 16 halt
	endtask

	task automatic runReference();
		int steps;
		steps = runModel(stepLimit);
		assert (steps > 0) else begin
			$display("reference model never reached the halt loop of the program");
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// compares pc and every register with the model
	always begin : compareRegs
		logic [31:0] data;
		logic [1:0] resp;
		@(checkRequest);
		axiRead(16'h0008, data, resp);
		checkValue("pc", data, modelPc);
		checkValue("pc read response", {30'h0, resp}, {30'h0, respOkay});
		for (int r = 0; r < 32; r++) begin
			axiRead(16'h0100 + 16'(4 * r), data, resp);
			checkValue($sformatf("register %0d", r), data, modelRegs[r]);
		end
		->checkDone;
	end

	initial begin
		#(watchdogNs);
		$display("watchdog expired after %0d ns, the core or the bus hung", watchdogNs);
		$display("Test failed");
		$fatal(1);
	end

	initial begin : mainSequence
		logic [31:0] data;
		logic [1:0] resp;
		clk = 1'b0;
		reset = 1'b1;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		seed = 87336;
		readyDelay = 0;
		clearModel();
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		axiRead(16'h0004, data, resp);
		checkValue("status after reset", data, 32'h0);
		axiRead(16'h0000, data, resp);
		checkValue("control after reset", data, 32'h0);
		axiRead(16'h0200, data, resp);
		checkValue("unmapped read", data, 32'h0);
		checkValue("unmapped read response", {30'h0, resp}, {30'h0, respOkay});
		writeExpect(16'h0004, 32'h1, respSlvErr, "status write response");

		buildAluProgram();
		loadProgram();
		runReference();
		startAndWait();
		->checkRequest;
		@(checkDone);
		writeExpect(16'h1000, 32'h0, respSlvErr, "imem write while running");
		writeExpect(16'h0000, 32'h0, respOkay, "stop response");

		buildMemProgram();
		loadProgram();
		runReference();
		startAndWait();
		->checkRequest;
		@(checkDone);
		writeExpect(16'h0000, 32'h0, respOkay, "stop response");

		buildBranchProgram();
		loadProgram();
		runReference();
		startAndWait();
		->checkRequest;
		@(checkDone);

		// rerun with slow ready, same expected state
		writeExpect(16'h0000, 32'h0, respOkay, "stop response");
		readyDelay = 3;
		startAndWait();
		->checkRequest;
		@(checkDone);
		writeExpect(16'h1004, 32'h0, respSlvErr, "imem write while running");

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+test
logic/cpuPkg.sv
logic/coreCtrlIf.sv
logic/controlUnit.sv
logic/alu.sv
logic/registerFile.sv
logic/dataMemory.sv
logic/cpuCore.sv
logic/hostRegs.sv
logic/cpuTop.sv
test/cpuTb.sv

/* Makefile */
TOP = cpuTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
